// File: verilog/seg_pkg.sv
// register map, display config struct, bcd digit type, converter states, scan constants
package seg_pkg;

    // --------------------------------------------------
    // avalon bus geometry
    // --------------------------------------------------
    localparam int ADDR_W = 2;      // word address, four registers
    localparam int DATA_W = 32;     // slave data bus

    // register map, one register per word
    localparam logic [ADDR_W-1:0] ADDR_VALUE = 2'd0;   // display value
    localparam logic [ADDR_W-1:0] ADDR_POINT = 2'd1;   // decimal point mask
    localparam logic [ADDR_W-1:0] ADDR_SIGN  = 2'd2;   // minus sign flag
    localparam logic [ADDR_W-1:0] ADDR_EN    = 2'd3;   // display enable

    // --------------------------------------------------
    // display geometry
    // --------------------------------------------------
    localparam int VALUE_W    = 20;                     // binary value width
    localparam int NUM_DIGITS = 6;                      // digits on the module
    localparam int DIGIT_W    = 4;                      // one bcd nibble
    localparam int BCD_W      = NUM_DIGITS * DIGIT_W;   // 24 bits of bcd
    localparam int IDX_W      = $clog2(NUM_DIGITS);     // digit index width
    localparam int STEP_W     = $clog2(VALUE_W);        // shift step counter

    // largest value six digits can show
    localparam logic [VALUE_W-1:0] BCD_MAX = 20'd999999;

    // --------------------------------------------------
    // scan timing and segment codes
    // --------------------------------------------------
    // kept tiny for simulation; a board wants something near 1 ms per digit
    localparam int SCAN_DIV   = 8;
    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

    localparam int SEG_W  = 8;      // g..a plus point
    localparam int SEG_DP = 7;      // decimal point bit

    // active high, bit 6 = g ... bit 0 = a
    localparam logic [SEG_W-1:0] SEG_BLANK = 8'h00;   // all dark
    localparam logic [SEG_W-1:0] SEG_MINUS = 8'h40;   // segment g only

    // --------------------------------------------------
    // shared types
    // --------------------------------------------------
    // register file output, 28 bits
    typedef struct packed {
        logic [VALUE_W-1:0]    value;   // number to show
        logic [NUM_DIGITS-1:0] point;   // bit i lights the point on digit i
        logic                  sign;    // show a leading minus
        logic                  en;      // scan on
    } disp_cfg_t;

    // digit 5 is the leftmost, most significant
    typedef logic [NUM_DIGITS-1:0][DIGIT_W-1:0] bcd_digits_t;

    // double dabble sequencer
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // waiting for a start
        SHIFT = 2'd1,   // one add-3 and shift per cycle
        DONE  = 2'd2    // publish the digits
    } conv_state_t;

endpackage

// File: verilog/seg_regs.sv
// avalon-mm register file with write decode, registered read-back and value update pulse
`timescale 1ns/1ps

module seg_regs (
    input  logic                           clk,
    input  logic                           rst_n,

    // avalon-mm slave, no wait states
    input  logic [seg_pkg::ADDR_W-1:0]     avs_address,
    input  logic                           avs_write,
    input  logic [seg_pkg::DATA_W-1:0]     avs_writedata,
    input  logic                           avs_read,
    output logic [seg_pkg::DATA_W-1:0]     avs_readdata,   // valid one cycle after avs_read

    // to the display core
    output seg_pkg::disp_cfg_t             cfg,
    output logic                           value_upd       // one cycle after a value write
);

    logic [seg_pkg::DATA_W-1:0] rd_mux;   // read data before the output register

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------
    // each field masked to its own width, upper bits dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;   // value, point, sign, en all clear
        end else if (avs_write) begin
            case (avs_address)
                seg_pkg::ADDR_VALUE: cfg.value <= avs_writedata[seg_pkg::VALUE_W-1:0];
                seg_pkg::ADDR_POINT: cfg.point <= avs_writedata[seg_pkg::NUM_DIGITS-1:0];
                seg_pkg::ADDR_SIGN:  cfg.sign  <= avs_writedata[0];
                seg_pkg::ADDR_EN:    cfg.en    <= avs_writedata[0];
                default: ;
            endcase
        end
    end

    // kicks the converter; lines up with the new cfg.value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_upd <= 1'b0;
        end else begin
            value_upd <= avs_write && (avs_address == seg_pkg::ADDR_VALUE);
        end
    end

    // --------------------------------------------------
    // read-back
    // --------------------------------------------------
    always_comb begin
        rd_mux = '0;   // unused bits read as zero
        case (avs_address)
            seg_pkg::ADDR_VALUE: rd_mux[seg_pkg::VALUE_W-1:0]    = cfg.value;
            seg_pkg::ADDR_POINT: rd_mux[seg_pkg::NUM_DIGITS-1:0] = cfg.point;
            seg_pkg::ADDR_SIGN:  rd_mux[0]                       = cfg.sign;
            seg_pkg::ADDR_EN:    rd_mux[0]                       = cfg.en;
            default: ;
        endcase
    end

    // fixed latency of one, held until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avs_readdata <= '0;
        end else if (avs_read) begin
            avs_readdata <= rd_mux;
        end
    end

    // host never issues both in one cycle
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(avs_write && avs_read)
    ) else $error("seg_regs: avs_write and avs_read both high");

endmodule

// File: verilog/bin_to_bcd.sv
// sequential double-dabble binary to bcd converter with saturation at 999999
`timescale 1ns/1ps

module bin_to_bcd (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,          // load bin and convert
    input  logic [seg_pkg::VALUE_W-1:0]   bin,
    output seg_pkg::bcd_digits_t          digits,         // last finished result
    output logic                          digits_valid    // strobe when digits update
);

    seg_pkg::conv_state_t              state;
    logic [seg_pkg::STEP_W-1:0]        step_cnt;   // shifts done so far
    seg_pkg::bcd_digits_t              bcd_q;      // bcd half of the shift register
    logic [seg_pkg::VALUE_W-1:0]       bin_q;      // binary half, shifted out msb first
    logic [seg_pkg::VALUE_W-1:0]       bin_sat;    // input clamped to six digits
    logic [seg_pkg::BCD_W+seg_pkg::VALUE_W-1:0] step;   // one add-3 plus shift

    // add 3 to every nibble that is 5 or more
    function automatic seg_pkg::bcd_digits_t add3(input seg_pkg::bcd_digits_t b);
        seg_pkg::bcd_digits_t r;
        r = b;
        for (int k = 0; k < seg_pkg::NUM_DIGITS; k++) begin
            if (r[k] >= 4'd5) begin
                r[k] = r[k] + 4'd3;
            end
        end
        return r;
    endfunction

    // anything past 999999 shows as all nines
    assign bin_sat = (bin > seg_pkg::BCD_MAX) ? seg_pkg::BCD_MAX : bin;

    assign step = {add3(bcd_q), bin_q} << 1;

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------
    // start wins in every state, so a new value restarts the run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= seg_pkg::IDLE;
            step_cnt     <= '0;
            digits       <= '0;
            digits_valid <= 1'b0;
        end else begin
            digits_valid <= 1'b0;   // strobe by default
            if (start) begin
                state    <= seg_pkg::SHIFT;
                step_cnt <= '0;
            end else begin
                case (state)
                    seg_pkg::SHIFT: begin
                        if (step_cnt == seg_pkg::STEP_W'(seg_pkg::VALUE_W - 1)) begin
                            state <= seg_pkg::DONE;   // 20th shift this cycle
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                    seg_pkg::DONE: begin
                        digits       <= bcd_q;   // only place digits changes
                        digits_valid <= 1'b1;
                        state        <= seg_pkg::IDLE;
                    end
                    default: state <= seg_pkg::IDLE;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // shift register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            bcd_q <= '0;
            bin_q <= bin_sat;
        end else if (state == seg_pkg::SHIFT) begin
            bcd_q <= step[seg_pkg::BCD_W+seg_pkg::VALUE_W-1:seg_pkg::VALUE_W];
            bin_q <= step[seg_pkg::VALUE_W-1:0];
        end
    end

    // a decimal digit reaching the scanner never exceeds 9
    for (genvar g = 0; g < seg_pkg::NUM_DIGITS; g++) begin : g_digit_chk
        a_digit_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            digits[g] <= 4'd9
        ) else $error("bin_to_bcd: digits[%0d] = 0x%h out of range", g, digits[g]);
    end

endmodule

// File: verilog/seg_scan.sv
// digit multiplexer with leading-zero blanking, minus sign, decimal point and segment decode
`timescale 1ns/1ps

module seg_scan (
    input  logic                           clk,
    input  logic                           rst_n,
    input  seg_pkg::disp_cfg_t             cfg,
    input  seg_pkg::bcd_digits_t           digits,
    output logic [seg_pkg::NUM_DIGITS-1:0] sel,    // one-hot, bit 5 leftmost
    output logic [seg_pkg::SEG_W-1:0]      seg     // active high, bit 7 point
);

    localparam logic [seg_pkg::IDX_W-1:0] IDX_TOP = seg_pkg::IDX_W'(seg_pkg::NUM_DIGITS - 1);

    logic [seg_pkg::SCAN_CNT_W-1:0] div_cnt;    // cycles spent on this digit
    logic [seg_pkg::IDX_W-1:0]      idx;        // digit being driven next
    logic [seg_pkg::IDX_W-1:0]      lead;       // most significant digit shown
    logic                           shown;      // idx carries a numeral
    logic                           minus_here; // idx carries the sign
    logic [seg_pkg::SEG_W-1:0]      body;       // segments before the point
    logic [seg_pkg::NUM_DIGITS-1:0] sel_next;
    logic [seg_pkg::SEG_W-1:0]      seg_next;

    // bcd nibble to g..a
    function automatic logic [6:0] seg7(input logic [seg_pkg::DIGIT_W-1:0] d);
        logic [6:0] s;
        case (d)
            4'd0:    s = 7'h3f;
            4'd1:    s = 7'h06;
            4'd2:    s = 7'h5b;
            4'd3:    s = 7'h4f;
            4'd4:    s = 7'h66;
            4'd5:    s = 7'h6d;
            4'd6:    s = 7'h7d;
            4'd7:    s = 7'h07;
            4'd8:    s = 7'h7f;
            4'd9:    s = 7'h6f;
            default: s = 7'h00;   // not a decimal digit, leave dark
        endcase
        return s;
    endfunction

    // --------------------------------------------------
    // leading digit, blanking and sign
    // --------------------------------------------------
    // highest nonzero digit; all zero leaves digit 0
    always_comb begin
        lead = '0;
        for (int i = 0; i < seg_pkg::NUM_DIGITS; i++) begin
            if (digits[i] != '0) begin
                lead = seg_pkg::IDX_W'(i);
            end
        end
    end

    assign shown = (idx <= lead);   // digit 0 always passes
    // sign sits one left of the lead, dropped when six digits are in use
    assign minus_here = cfg.sign && (lead != IDX_TOP) && (idx == lead + 1'b1);

    always_comb begin
        if (shown) begin
            body = {1'b0, seg7(digits[idx])};
        end else if (minus_here) begin
            body = seg_pkg::SEG_MINUS;
        end else begin
            body = seg_pkg::SEG_BLANK;
        end
        seg_next               = body;
        seg_next[seg_pkg::SEG_DP] = cfg.point[idx];   // point lights on blank digits too
    end

    always_comb begin
        sel_next      = '0;
        sel_next[idx] = 1'b1;
    end

    // --------------------------------------------------
    // scan counters and output registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            idx     <= IDX_TOP;
            sel     <= '0;
            seg     <= seg_pkg::SEG_BLANK;
        end else if (!cfg.en) begin
            div_cnt <= '0;       // park on the leftmost digit
            idx     <= IDX_TOP;
            sel     <= '0;
            seg     <= seg_pkg::SEG_BLANK;
        end else begin
            sel <= sel_next;
            seg <= seg_next;
            if (div_cnt == seg_pkg::SCAN_CNT_W'(seg_pkg::SCAN_DIV - 1)) begin
                div_cnt <= '0;
                idx     <= (idx == '0) ? IDX_TOP : idx - 1'b1;   // right, then wrap
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // exactly one digit lit after every enabled edge, idx stays on a real digit
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg.en |=> $onehot(sel)
    ) else $error("seg_scan: sel = 0x%h not one-hot while scanning", sel);

endmodule

// File: verilog/segled_top.sv
// top level joining the register file, bcd converter and digit scanner
`timescale 1ns/1ps

module segled_top (
    input  logic                           clk,
    input  logic                           rst_n,

    // avalon-mm slave
    input  logic [seg_pkg::ADDR_W-1:0]     avs_address,
    input  logic                           avs_write,
    input  logic [seg_pkg::DATA_W-1:0]     avs_writedata,
    input  logic                           avs_read,
    output logic [seg_pkg::DATA_W-1:0]     avs_readdata,

    // display pins
    output logic [seg_pkg::NUM_DIGITS-1:0] sel,   // digit select, bit 5 leftmost
    output logic [seg_pkg::SEG_W-1:0]      seg    // segments g..a and point
);

    seg_pkg::disp_cfg_t   cfg;            // register contents
    logic                 value_upd;      // new value written
    seg_pkg::bcd_digits_t digits;         // decimal digits of cfg.value
    logic                 digits_valid;   // conversion finished strobe

    // --------------------------------------------------
    // host side
    // --------------------------------------------------
    seg_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .avs_address   (avs_address),
        .avs_write     (avs_write),
        .avs_writedata (avs_writedata),
        .avs_read      (avs_read),
        .avs_readdata  (avs_readdata),
        .cfg           (cfg),
        .value_upd     (value_upd)
    );

    // --------------------------------------------------
    // display core
    // --------------------------------------------------
    bin_to_bcd u_bcd (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (value_upd),
        .bin          (cfg.value),
        .digits       (digits),
        .digits_valid (digits_valid)
    );

    seg_scan u_scan (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .digits (digits),
        .sel    (sel),
        .seg    (seg)
    );

endmodule

// File: dv/segled_tb.sv
// testbench for segled_top with clock, reset, avalon tasks, scan capture, display model and report
`timescale 1ns/1ps

module segled_tb;

    localparam int CLK_HALF   = 2;     // 4 ns period
    localparam int RST_CYCLES = 16;
    localparam int WAIT_MAX   = 200;   // per wait loop, well over one scan round
    localparam int CONV_MAX   = 30;    // a conversion ends 21 cycles after its start

    // reference segment table, g..a for 0..9
    localparam logic [6:0] SEG_TABLE [10] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66,
                                              7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f};

    // sign test values, short ones and two that fill all six digits
    localparam logic [19:0] SIGN_VALUES [6] = '{20'd0, 20'd7, 20'd42, 20'd12345,
                                                20'd123456, 20'd999999};

    logic        clk;
    logic        rst_n;
    logic [1:0]  avs_address;
    logic        avs_write;
    logic [31:0] avs_writedata;
    logic        avs_read;
    logic [31:0] avs_readdata;
    logic [5:0]  sel;
    logic [7:0]  seg;

    int         errors;
    int         checks;
    int         tests;
    logic [7:0] cap [6];   // last captured frame, index = digit

    segled_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .avs_address   (avs_address),
        .avs_write     (avs_write),
        .avs_writedata (avs_writedata),
        .avs_read      (avs_read),
        .avs_readdata  (avs_readdata),
        .sel           (sel),
        .seg           (seg)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // --------------------------------------------------
    // reference model and checks
    // --------------------------------------------------
    // expected segments on one digit from the display rules
    function automatic logic [7:0] expected_seg(input logic [19:0] value, input logic [5:0] point,
                                                input logic sign, input logic [2:0] pos);
        int unsigned sat;
        int unsigned scale;
        logic [3:0]  digit [6];
        logic [2:0]  lead;
        logic [7:0]  s;
        sat = 32'(value);
        if (sat > 32'(seg_pkg::BCD_MAX)) begin
            sat = 32'(seg_pkg::BCD_MAX);   // clamp to six nines
        end
        scale = 1;
        lead  = 3'd0;
        for (int i = 0; i < 6; i++) begin
            digit[i] = 4'((sat / scale) % 10);
            if (digit[i] != 4'd0) begin
                lead = 3'(i);   // highest nonzero wins
            end
            scale = scale * 10;
        end
        if (pos <= lead) begin
            s = {1'b0, SEG_TABLE[digit[pos]]};
        end else if (sign && lead < 3'd5 && pos == lead + 3'd1) begin
            s = seg_pkg::SEG_MINUS;
        end else begin
            s = seg_pkg::SEG_BLANK;
        end
        s[7] = point[pos];   // point also on dark digits
        return s;
    endfunction

    // readable bits per register
    function automatic logic [31:0] field_mask(input logic [1:0] addr);
        case (addr)
            seg_pkg::ADDR_VALUE: return 32'h000f_ffff;
            seg_pkg::ADDR_POINT: return 32'h0000_003f;
            default:             return 32'h0000_0001;   // sign and enable
        endcase
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %-10s %s, %0d errors", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    // --------------------------------------------------
    // avalon tasks
    // --------------------------------------------------
    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        avs_address   <= addr;
        avs_writedata <= data;
        avs_write     <= 1'b1;
        @(posedge clk);
        avs_write     <= 1'b0;
    endtask

    // readdata lands one cycle after avs_read
    task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
        @(posedge clk);
        avs_address <= addr;
        avs_read    <= 1'b1;
        @(posedge clk);
        avs_read    <= 1'b0;
        @(negedge clk);
        data = avs_readdata;
    endtask

    // --------------------------------------------------
    // scan monitor
    // --------------------------------------------------
    // loop until sel equals (or leaves) target, sampled on falling edges
    task automatic wait_sel(input logic [5:0] target, input bit want_match, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < WAIT_MAX && !ok; n++) begin
            @(negedge clk);
            ok = ((sel == target) == want_match);
        end
        if (!ok) begin
            $display("timeout while waiting for sel to %s 0x%h",
                     want_match ? "reach" : "leave", target);
            errors++;
        end
    endtask

    // converter done strobe after a value write
    task automatic wait_digits(output bit ok);
        ok = 1'b0;
        @(negedge clk);   // start cycle, an older run may still strobe here
        for (int n = 0; n < CONV_MAX && !ok; n++) begin
            @(negedge clk);
            ok = UUT.digits_valid;
        end
        if (!ok) begin
            $display("timeout while waiting for digits_valid after a value write");
            errors++;
        end
    endtask

    // one full round from the start of digit 5, sampled mid slot
    task automatic capture_frame(output bit ok);
        logic [5:0] target;
        logic [2:0] pos;
        wait_sel(6'b100000, 1'b0, ok);
        if (ok) begin
            wait_sel(6'b100000, 1'b1, ok);   // first cycle of the leftmost slot
        end
        for (int k = 5; k >= 0 && ok; k--) begin
            pos    = 3'(k);
            target = 6'b1 << pos;
            if (k != 5) begin
                wait_sel(target, 1'b1, ok);
            end
            if (ok) begin
                repeat (seg_pkg::SCAN_DIV / 2 - 1) @(negedge clk);
                cap[pos] = seg;
                check_hex("sel", 32'(sel), 32'(target));   // still in the slot
            end
        end
    endtask

    task automatic compare_frame(input logic [19:0] value, input logic [5:0] point,
                                 input logic sign);
        for (int k = 0; k < 6; k++) begin
            check_hex($sformatf("seg on digit %0d for value 0x%h", k, value),
                      32'(cap[k]), 32'(expected_seg(value, point, sign, 3'(k))));
        end
    endtask

    task automatic show_and_check(input logic [19:0] value, input logic [5:0] point,
                                  input logic sign);
        bit ok;
        write_reg(seg_pkg::ADDR_POINT, 32'(point));
        write_reg(seg_pkg::ADDR_SIGN, 32'(sign));
        write_reg(seg_pkg::ADDR_VALUE, 32'(value));   // last, starts the conversion
        wait_digits(ok);
        if (ok) begin
            capture_frame(ok);
        end
        if (ok) begin
            compare_frame(value, point, sign);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] wdata;
        logic [31:0] rdata;
        int unsigned lim;
        int          mark;
        int          cycles;
        bit          ok;
        logic [7:0]  prev [6];
        errors        = 0;
        checks        = 0;
        tests         = 0;
        rst_n         = 1'b0;
        avs_address   = 2'd0;
        avs_write     = 1'b0;
        avs_writedata = 32'd0;
        avs_read      = 1'b0;
        void'($urandom(83));
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // idle after reset
        mark = errors;
        repeat (100) begin
            @(negedge clk);
            check_hex("sel", 32'(sel), 32'd0);
            check_hex("seg", 32'(seg), 32'(seg_pkg::SEG_BLANK));
        end
        for (int a = 0; a < 4; a++) begin
            read_reg(2'(a), rdata);
            check_hex("avs_readdata", rdata, 32'd0);
        end
        report_test("reset", mark);

        // read-back masked to field width
        mark = errors;
        for (int r = 0; r < 4; r++) begin
            for (int a = 0; a < 4; a++) begin
                wdata = $urandom;
                write_reg(2'(a), wdata);
                read_reg(2'(a), rdata);
                check_hex("avs_readdata", rdata, wdata & field_mask(2'(a)));
            end
        end
        report_test("readback", mark);

        // plain decimal values, zero first
        mark = errors;
        write_reg(seg_pkg::ADDR_EN, 32'd1);
        show_and_check(20'd0, 6'd0, 1'b0);
        repeat (6) begin
            lim = 1;
            repeat (1 + $urandom % 6) lim = lim * 10;   // 1 to 6 digits
            show_and_check(20'($urandom % lim), 6'd0, 1'b0);
        end
        report_test("value", mark);

        // anything past six digits
        mark = errors;
        show_and_check(20'd1000000, 6'd0, 1'b0);
        show_and_check(20'hfffff, 6'd0, 1'b0);
        repeat (3) begin
            show_and_check(20'(1000000 + $urandom % 48576), 6'd0, 1'b0);
        end
        report_test("saturate", mark);

        // minus placement and random point masks
        mark = errors;
        for (int v = 0; v < 6; v++) begin
            show_and_check(SIGN_VALUES[v], 6'($urandom), 1'b1);
        end
        show_and_check(20'($urandom % 1000), 6'($urandom), 1'b1);
        report_test("sign_point", mark);

        // enable off then on again
        mark = errors;
        prev = cap;
        write_reg(seg_pkg::ADDR_EN, 32'd0);
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < 10) begin
            @(negedge clk);
            cycles++;
            ok = (sel == 6'd0);
        end
        checks++;
        assert (ok && cycles <= 2) else begin
            $display("sel did not go to zero within two cycles of clearing en (%0d)", cycles);
            errors++;
        end
        repeat (30) begin
            @(negedge clk);
            check_hex("sel", 32'(sel), 32'd0);
        end
        write_reg(seg_pkg::ADDR_EN, 32'd1);
        wait_sel(6'd0, 1'b0, ok);
        if (ok) begin
            check_hex("sel", 32'(sel), 32'h20);   // restart at the leftmost digit
            capture_frame(ok);
        end
        if (ok) begin
            for (int k = 0; k < 6; k++) begin
                check_hex($sformatf("seg on digit %0d after re-enable", k),
                          32'(cap[k]), 32'(prev[k]));
            end
        end
        report_test("enable", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/seg_pkg.sv
verilog/seg_regs.sv
verilog/bin_to_bcd.sv
verilog/seg_scan.sv
verilog/segled_top.sv
dv/segled_tb.sv

// File: run.sh
#!/bin/sh
# build and run the segled testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module segled_tb \
    -o segled_sim

# keep the output even when the simulation exits with an error
out="$(./obj_dir/segled_sim 2>&1)" || true
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
